// File: sim.f
src/dma_pkg.sv
src/dma_ctrl.sv
src/chunk_head.sv
src/addr_looper.sv
src/write_collector.sv
src/bank_swizzle.sv
src/dma_pipeline.sv
test/dma_pipeline_tb.sv

// File: Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --timing --top-module dma_pipeline_tb -f sim.f -o Vdma_pipeline_tb
	./obj_dir/Vdma_pipeline_tb | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/dma_pipeline_tb.sv
// Testbench with clock, reset, DUT, DRAM responder, write monitor, checks and directed tests

`timescale 1ns/1ps

module dma_pipeline_tb
	import dma_pkg::*;
();

localparam int HBW     = 4;
localparam int TIMEOUT = 2000;

logic           i_clk = 1'b0;
logic           i_rst_n = 1'b0;
logic           i_req_valid = 1'b0;
dma_req_t       i_req = '0;
logic           o_req_ready;
logic           o_dram_addr_valid;
logic           i_dram_addr_ready = 1'b0;
logic [GBW-1:0] o_dram_addr;
logic           i_dram_data_valid = 1'b0;
logic           o_dram_data_ready;
data_vec_t      i_dram_data = '0;
logic           o_wr_valid;
logic [HBW-1:0] o_wr_addr;
data_vec_t      o_wr_data;

integer seed = 97251;
int     addr_stall = 0;
int     max_delay = 0;
int     wait_cnt = 0;
int     err_cnt = 0;
int     pass_cnt = 0;
int     fail_cnt = 0;

// Reads waiting for their burst, and everything seen on the ports
logic [GBW-1:0] pend_q[$];
logic [GBW-1:0] dram_log[$];
logic [HBW-1:0] wr_addr_log[$];
data_vec_t      wr_data_log[$];
logic [GBW-1:0] exp_dram_q[$];
logic [HBW-1:0] exp_wa_q[$];
data_vec_t      exp_wd_q[$];

dma_pipeline #(.HBW(HBW)) i_dma_pipeline(
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.i_req_valid(i_req_valid),
	.o_req_ready(o_req_ready),
	.i_req(i_req),
	.o_dram_addr_valid(o_dram_addr_valid),
	.i_dram_addr_ready(i_dram_addr_ready),
	.o_dram_addr(o_dram_addr),
	.i_dram_data_valid(i_dram_data_valid),
	.o_dram_data_ready(o_dram_data_ready),
	.i_dram_data(i_dram_data),
	.o_wr_valid(o_wr_valid),
	.o_wr_addr(o_wr_addr),
	.o_wr_data(o_wr_data)
);

always #4 i_clk = ~i_clk;

// Word k of a burst is the low bits of its address plus k
function automatic data_vec_t burst_of(input logic [GBW-1:0] a);
	data_vec_t b;
	for (int k = 0; k < VSIZE; k++) begin
		b[k] = a + 16'(k);
	end
	return b;
endfunction

//========================================
// DRAM responder and write monitor
//========================================
always @(posedge i_clk) begin
	if (o_dram_addr_valid && i_dram_addr_ready) begin
		pend_q.push_back(o_dram_addr);
		dram_log.push_back(o_dram_addr);
	end
	i_dram_addr_ready <= ($unsigned($random(seed)) % 16) >= addr_stall;
	if (i_dram_data_valid && o_dram_data_ready) begin
		i_dram_data_valid <= 1'b0;
		void'(pend_q.pop_front());
	end else if (!i_dram_data_valid && pend_q.size() > 0) begin
		if (wait_cnt > 0) begin
			wait_cnt = wait_cnt - 1;
		end else begin
			i_dram_data_valid <= 1'b1;
			i_dram_data <= burst_of(pend_q[0]);
			wait_cnt = int'($unsigned($random(seed)) % (max_delay + 1));
		end
	end
end

always @(posedge i_clk) begin
	if (i_rst_n && o_wr_valid) begin
		wr_addr_log.push_back(o_wr_addr);
		wr_data_log.push_back(o_wr_data);
	end
end

//========================================
// Reference model and checks
//========================================
function automatic dma_req_t make_req(input logic [15:0] base, input int x0, input int y0,
	input int width, input int height, input int rows, input int sram_row,
	input logic [15:0] pad, input int xor_mask);
	dma_req_t r;
	r.base_addr = base;
	r.x0        = CBW'(x0);
	r.y0        = CBW'(y0);
	r.width     = DIM_BW'(width);
	r.height    = DIM_BW'(height);
	r.rows      = ROW_BW'(rows);
	r.sram_row  = 8'(sram_row);
	r.pad_value = pad;
	r.xor_mask  = LANE_BW'(xor_mask);
	return r;
endfunction

// Appends the reads and writes one tile must produce
function automatic void add_expected(input dma_req_t r);
	int        x0;
	int        y0;
	int        y;
	int        addr;
	int        wa;
	int        sel;
	bit        fetch;
	data_vec_t lanes;
	data_vec_t outw;
	x0 = int'($signed(r.x0));
	y0 = int'($signed(r.y0));
	for (int i = 0; i < int'(r.rows); i++) begin
		y = y0 + i;
		fetch = (y >= 0) && (y < int'(r.height));
		addr = (int'(r.base_addr) + y * int'(r.width) + x0) & 'hFFFF;
		if (fetch) begin
			exp_dram_q.push_back(GBW'(addr));
		end
		for (int k = 0; k < VSIZE; k++) begin
			if (fetch && x0 + k >= 0 && x0 + k < int'(r.width)) begin
				lanes[k] = DATA_BW'(addr + k);
			end else begin
				lanes[k] = r.pad_value;
			end
		end
		wa = (int'(r.sram_row) + i) % (1 << HBW);
		sel = (wa % (1 << LANE_BW)) & int'(r.xor_mask);
		for (int j = 0; j < VSIZE; j++) begin
			outw[j] = lanes[j ^ sel];
		end
		exp_wa_q.push_back(HBW'(wa));
		exp_wd_q.push_back(outw);
	end
endfunction

task automatic check_value(input string name, input logic [63:0] expv, input logic [63:0] actv);
	if (expv !== actv) begin
		$display("Fail %s: expected %h, actual %h", name, expv, actv);
		err_cnt++;
	end
endtask

task automatic compare_results(input string name);
	check_value({name, " read count"}, 64'(exp_dram_q.size()), 64'(dram_log.size()));
	for (int i = 0; i < exp_dram_q.size() && i < dram_log.size(); i++) begin
		check_value($sformatf("%s read %0d addr", name, i), 64'(exp_dram_q[i]),
			64'(dram_log[i]));
	end
	check_value({name, " write count"}, 64'(exp_wd_q.size()), 64'(wr_data_log.size()));
	for (int i = 0; i < exp_wd_q.size() && i < wr_data_log.size(); i++) begin
		check_value($sformatf("%s write %0d addr", name, i), 64'(exp_wa_q[i]),
			64'(wr_addr_log[i]));
		check_value($sformatf("%s write %0d data", name, i), 64'(exp_wd_q[i]),
			64'(wr_data_log[i]));
	end
endtask

//========================================
// Stimulus helpers
//========================================
task automatic clear_logs();
	dram_log.delete();
	wr_addr_log.delete();
	wr_data_log.delete();
	exp_dram_q.delete();
	exp_wa_q.delete();
	exp_wd_q.delete();
endtask

task automatic send_req(input dma_req_t r);
	int n;
	n = 0;
	i_req <= r;
	i_req_valid <= 1'b1;
	@(posedge i_clk);
	while (!o_req_ready && n < TIMEOUT) begin
		@(posedge i_clk);
		n++;
	end
	if (!o_req_ready) begin
		$display("Request was never accepted by the DUT");
		err_cnt++;
	end
	i_req_valid <= 1'b0;
endtask

task automatic wait_writes(input int count);
	int n;
	n = 0;
	while (wr_data_log.size() < count && n < TIMEOUT) begin
		@(posedge i_clk);
		n++;
	end
	if (wr_data_log.size() < count) begin
		$display("Only %0d of %0d SRAM writes arrived in time", wr_data_log.size(), count);
		err_cnt++;
	end
endtask

task automatic wait_idle();
	int n;
	n = 0;
	while (!o_req_ready && n < TIMEOUT) begin
		@(posedge i_clk);
		n++;
	end
	if (!o_req_ready) begin
		$display("Request ready never came back after the tile");
		err_cnt++;
	end
endtask

task automatic run_tile(input string name, input dma_req_t r);
	clear_logs();
	add_expected(r);
	send_req(r);
	wait_writes(exp_wd_q.size());
	wait_idle();
	compare_results(name);
endtask

task automatic end_test(input string name);
	if (err_cnt == 0) begin
		pass_cnt++;
		$display("%s: passed", name);
	end else begin
		fail_cnt++;
		$display("%s: failed with %0d errors", name, err_cnt);
	end
	err_cnt = 0;
endtask

//========================================
// Directed tests
//========================================
task automatic test_in_bounds();
	addr_stall = 0;
	max_delay = 0;
	check_value("in-bounds ready after reset", 64'(1), 64'(o_req_ready));
	check_value("in-bounds address valid after reset", 64'(0), 64'(o_dram_addr_valid));
	check_value("in-bounds data ready after reset", 64'(0), 64'(o_dram_data_ready));
	check_value("in-bounds write valid after reset", 64'(0), 64'(o_wr_valid));
	run_tile("in-bounds", make_req(16'h1000, 2, 1, 16, 10, 4, 0, 16'hdead, 0));
	end_test("in-bounds");
endtask

task automatic test_row_padding();
	addr_stall = 4;
	max_delay = 2;
	// Rows at y -2, -1, 5 and 6 fall outside
	run_tile("row padding", make_req(16'h2000, 0, -2, 8, 5, 9, 3, 16'hbeef, 0));
	end_test("row padding");
endtask

task automatic test_col_padding();
	addr_stall = 4;
	max_delay = 2;
	run_tile("column left", make_req(16'h3000, -1, 0, 12, 6, 3, 0, 16'h5a5a, 0));
	// Columns 12 and 13 lie past the right edge
	run_tile("column right", make_req(16'h3100, 10, 2, 12, 6, 3, 4, 16'ha5a5, 0));
	end_test("column padding");
endtask

task automatic test_swizzle();
	addr_stall = 4;
	max_delay = 2;
	run_tile("bank swizzle", make_req(16'h4000, 4, 0, 20, 20, 8, 6, 16'h1111, 3));
	end_test("bank swizzle");
endtask

task automatic test_backpressure();
	addr_stall = 12;
	max_delay = 6;
	// Addresses and burst words wrap past the top of DRAM
	run_tile("back-pressure", make_req(16'hffe0, -2, -1, 9, 9, 12, 14, 16'h7777, 2));
	end_test("back-pressure");
endtask

task automatic test_busy();
	dma_req_t a;
	dma_req_t b;
	int       first_cnt;
	addr_stall = 6;
	max_delay = 3;
	a = make_req(16'h5000, 1, 0, 10, 10, 5, 2, 16'h2222, 1);
	b = make_req(16'h6000, -3, 7, 10, 10, 6, 9, 16'h3333, 3);
	clear_logs();
	add_expected(a);
	first_cnt = exp_wd_q.size();
	add_expected(b);
	send_req(a);
	send_req(b);
	// The second request may only land once the first tile wrote everything
	check_value("busy handshake writes at second accept", 64'(first_cnt),
		64'(wr_data_log.size()));
	wait_writes(exp_wd_q.size());
	wait_idle();
	compare_results("busy handshake");
	end_test("busy handshake");
endtask

initial begin
	repeat (10) @(posedge i_clk);
	i_rst_n <= 1'b1;
	@(posedge i_clk);
	test_in_bounds();
	test_row_padding();
	test_col_padding();
	test_swizzle();
	test_backpressure();
	test_busy();
	$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
	if (fail_cnt == 0) begin
		$display("TEST PASS");
	end else begin
		$display("TEST FAIL");
	end
	$finish;
end

endmodule

// File: src/dma_pipeline.sv
// Tile-fetch DMA top level with control, chunk head, looper, collector and swizzle

`timescale 1ns/1ps

module dma_pipeline
	import dma_pkg::*;
#(
	parameter int HBW = 4
) (
	input  logic           i_clk,
	input  logic           i_rst_n,
	// Request
	input  logic           i_req_valid,
	output logic           o_req_ready,
	input  dma_req_t       i_req,
	// DRAM read address
	output logic           o_dram_addr_valid,
	input  logic           i_dram_addr_ready,
	output logic [GBW-1:0] o_dram_addr,
	// DRAM read data
	input  logic           i_dram_data_valid,
	output logic           o_dram_data_ready,
	input  data_vec_t      i_dram_data,
	// SRAM write
	output logic           o_wr_valid,
	output logic [HBW-1:0] o_wr_addr,
	output data_vec_t      o_wr_data
);

dma_req_t       active_req;
logic           start;
logic           tile_done;
logic           head_valid;
head_t          head;
logic           cmd_valid;
logic           cmd_ready;
row_cmd_t       cmd;
logic [HBW-1:0] cmd_row;
data_vec_t      wr_data_raw;

//========================================
// Control and head
//========================================
dma_ctrl i_dma_ctrl(
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.i_req_valid(i_req_valid),
	.o_req_ready(o_req_ready),
	.i_req(i_req),
	.o_active_req(active_req),
	.o_start(start),
	.i_tile_done(tile_done)
);

chunk_head i_chunk_head(
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.i_start(start),
	.i_req(active_req),
	.o_head_valid(head_valid),
	.o_head(head)
);

//========================================
// Datapath
//========================================
addr_looper #(.HBW(HBW)) i_addr_looper(
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.i_head_valid(head_valid),
	.i_head(head),
	.i_req(active_req),
	.o_dram_addr_valid(o_dram_addr_valid),
	.i_dram_addr_ready(i_dram_addr_ready),
	.o_dram_addr(o_dram_addr),
	.o_cmd_valid(cmd_valid),
	.i_cmd_ready(cmd_ready),
	.o_cmd(cmd),
	.o_cmd_row(cmd_row)
);

write_collector #(.HBW(HBW)) i_write_collector(
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.i_cmd_valid(cmd_valid),
	.o_cmd_ready(cmd_ready),
	.i_cmd(cmd),
	.i_cmd_row(cmd_row),
	.i_dram_data_valid(i_dram_data_valid),
	.o_dram_data_ready(o_dram_data_ready),
	.i_dram_data(i_dram_data),
	.i_pad_value(active_req.pad_value),
	.o_wr_valid(o_wr_valid),
	.o_wr_row(o_wr_addr),
	.o_wr_data(wr_data_raw),
	.o_tile_done(tile_done)
);

// Bank mask stays put until the next request
bank_swizzle #(.HBW(HBW)) i_bank_swizzle(
	.i_row(o_wr_addr),
	.i_xor_mask(active_req.xor_mask),
	.i_data(wr_data_raw),
	.o_data(o_wr_data)
);

endmodule

// File: src/bank_swizzle.sv
// Lane permutation of an SRAM write by XOR of row bits and bank mask

`timescale 1ns/1ps

module bank_swizzle
	import dma_pkg::*;
#(
	parameter int HBW = 4
) (
	input  logic [HBW-1:0]     i_row,
	input  logic [LANE_BW-1:0] i_xor_mask,
	input  data_vec_t          i_data,
	output data_vec_t          o_data
);

logic [LANE_BW-1:0] sel;

// Low row bits pick the rotation
assign sel = i_row[LANE_BW-1:0] & i_xor_mask;

always_comb begin
	for (int j = 0; j < VSIZE; j++) begin
		o_data[j] = i_data[LANE_BW'(j) ^ sel];
	end
end

endmodule

// File: src/write_collector.sv
// Row command and DRAM burst join with row and column padding

`timescale 1ns/1ps

module write_collector
	import dma_pkg::*;
#(
	parameter int HBW = 4
) (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_cmd_valid,
	output logic               o_cmd_ready,
	input  row_cmd_t           i_cmd,
	input  logic [HBW-1:0]     i_cmd_row,
	input  logic               i_dram_data_valid,
	output logic               o_dram_data_ready,
	input  data_vec_t          i_dram_data,
	input  logic [DATA_BW-1:0] i_pad_value,
	output logic               o_wr_valid,
	output logic [HBW-1:0]     o_wr_row,
	output data_vec_t          o_wr_data,
	output logic               o_tile_done
);

// Only fetch rows are held while their burst is awaited
logic             held;
logic [VSIZE-1:0] mask_q;
logic             last_q;
logic [HBW-1:0]   row_q;
logic             cmd_fire;
logic             data_fire;
logic             wr_next;
logic             last_sel;
data_vec_t        fill_data;

assign o_cmd_ready       = !held;
assign o_dram_data_ready = held;
assign cmd_fire  = i_cmd_valid && o_cmd_ready;
assign data_fire = i_dram_data_valid && o_dram_data_ready;

// Unfetched row goes straight out, fetched row after its burst
assign wr_next  = (cmd_fire && !i_cmd.fetch) || data_fire;
assign last_sel = held ? last_q : i_cmd.last;

// All pad when nothing is held
always_comb begin
	for (int k = 0; k < VSIZE; k++) begin
		fill_data[k] = (held && mask_q[k]) ? i_dram_data[k] : i_pad_value;
	end
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		held        <= 1'b0;
		o_wr_valid  <= 1'b0;
		o_tile_done <= 1'b0;
	end else begin
		o_wr_valid  <= wr_next;
		o_tile_done <= wr_next && last_sel;
		if (cmd_fire && i_cmd.fetch) begin
			held <= 1'b1;
		end else if (data_fire) begin
			held <= 1'b0;
		end
	end
end

always_ff @(posedge i_clk) begin
	if (cmd_fire) begin
		mask_q <= i_cmd.col_mask;
		last_q <= i_cmd.last;
		row_q  <= i_cmd_row;
	end
	if (wr_next) begin
		o_wr_row  <= held ? row_q : i_cmd_row;
		o_wr_data <= fill_data;
	end
end

endmodule

// File: src/addr_looper.sv
// Row walker issuing DRAM read addresses and per-row write commands

`timescale 1ns/1ps

module addr_looper
	import dma_pkg::*;
#(
	parameter int HBW = 4
) (
	input  logic           i_clk,
	input  logic           i_rst_n,
	input  logic           i_head_valid,
	input  head_t          i_head,
	input  dma_req_t       i_req,
	output logic           o_dram_addr_valid,
	input  logic           i_dram_addr_ready,
	output logic [GBW-1:0] o_dram_addr,
	output logic           o_cmd_valid,
	input  logic           i_cmd_ready,
	output row_cmd_t       o_cmd,
	output logic [HBW-1:0] o_cmd_row
);

// Signed row coordinate wide enough for y0 plus 15 rows
localparam int YW = CBW + 1;

logic              active;
logic              addr_sent;
logic              cmd_sent;
logic [ROW_BW-1:0] row_cnt;
logic [YW-1:0]     cur_y;
logic [VSIZE-1:0]  col_mask;
logic              fetch;
logic              last_row;
logic              addr_fire;
logic              cmd_fire;
logic              advance;

// Row inside the matrix
assign fetch    = !cur_y[YW-1] && (cur_y < YW'(i_req.height));
assign last_row = (ROW_BW+1)'(row_cnt) + 1'b1 >= (ROW_BW+1)'(i_req.rows);

assign o_dram_addr_valid = active && fetch && !addr_sent;
assign o_cmd_valid       = active && !cmd_sent;
assign addr_fire = o_dram_addr_valid && i_dram_addr_ready;
assign cmd_fire  = o_cmd_valid && i_cmd_ready;

// Both outputs done, or no address needed for this row
assign advance = active && (!fetch || addr_sent || addr_fire) && (cmd_sent || cmd_fire);

always_comb begin
	o_cmd.fetch    = fetch;
	o_cmd.col_mask = col_mask;
	o_cmd.last     = last_row;
end

//========================================
// Row state
//========================================
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		active    <= 1'b0;
		addr_sent <= 1'b0;
		cmd_sent  <= 1'b0;
		row_cnt   <= '0;
	end else if (i_head_valid) begin
		active    <= 1'b1;
		addr_sent <= 1'b0;
		cmd_sent  <= 1'b0;
		row_cnt   <= '0;
	end else if (advance) begin
		addr_sent <= 1'b0;
		cmd_sent  <= 1'b0;
		row_cnt   <= row_cnt + 1'b1;
		if (last_row) begin
			active <= 1'b0;
		end
	end else begin
		addr_sent <= addr_sent || addr_fire;
		cmd_sent  <= cmd_sent || cmd_fire;
	end
end

// Running address, coordinate and SRAM row
always_ff @(posedge i_clk) begin
	if (i_head_valid) begin
		o_dram_addr <= i_head.row0_addr;
		cur_y       <= YW'($signed(i_req.y0));
		col_mask    <= i_head.col_mask;
		o_cmd_row   <= i_req.sram_row[HBW-1:0];
	end else if (advance) begin
		o_dram_addr <= o_dram_addr + GBW'(i_req.width);
		cur_y       <= cur_y + 1'b1;
		o_cmd_row   <= o_cmd_row + 1'b1;
	end
end

endmodule

// File: src/chunk_head.sv
// First-row DRAM address and column-validity mask of a tile

`timescale 1ns/1ps

module chunk_head
	import dma_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_start,
	input  dma_req_t i_req,
	output logic     o_head_valid,
	output head_t    o_head
);

// Room for x0 + k and the sign
localparam int CX_BW = CBW + 2;

logic [GBW-1:0]                y0_ext;
logic [GBW-1:0]                x0_ext;
logic [GBW-1:0]                row_ofs;
logic [VSIZE-1:0][CX_BW-1:0]   lane_x;
logic [VSIZE-1:0]              col_mask;

assign y0_ext  = GBW'($signed(i_req.y0));
assign x0_ext  = GBW'($signed(i_req.x0));
// Sign extension keeps the modulo 2^GBW product exact
assign row_ofs = y0_ext * GBW'(i_req.width);

always_comb begin
	for (int k = 0; k < VSIZE; k++) begin
		lane_x[k]   = CX_BW'($signed(i_req.x0)) + CX_BW'(k);
		col_mask[k] = !lane_x[k][CX_BW-1] && (lane_x[k] < CX_BW'(i_req.width));
	end
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		o_head_valid <= 1'b0;
	end else begin
		o_head_valid <= i_start;
	end
end

always_ff @(posedge i_clk) begin
	if (i_start) begin
		o_head.row0_addr <= i_req.base_addr + row_ofs + x0_ext;
		o_head.col_mask  <= col_mask;
	end
end

endmodule

// File: src/dma_ctrl.sv
// Request handshake, active tile register and start/done tracking

`timescale 1ns/1ps

module dma_ctrl
	import dma_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_req_valid,
	output logic     o_req_ready,
	input  dma_req_t i_req,
	output dma_req_t o_active_req,
	output logic     o_start,
	input  logic     i_tile_done
);

logic busy;
logic req_fire;

// One tile at a time
assign o_req_ready = !busy;
assign req_fire = i_req_valid && o_req_ready;

//========================================
// Control
//========================================
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		busy    <= 1'b0;
		o_start <= 1'b0;
	end else begin
		o_start <= req_fire;
		if (req_fire) begin
			busy <= 1'b1;
		end else if (i_tile_done) begin
			busy <= 1'b0;
		end
	end
end

// Held until the next accepted request
always_ff @(posedge i_clk) begin
	if (req_fire) begin
		o_active_req <= i_req;
	end
end

endmodule

// File: src/dma_pkg.sv
// Shared widths, lane count and the request, head, row-command and data-row types

package dma_pkg;

	//========================================
	// Widths
	//========================================
	localparam int DATA_BW = 16;
	localparam int VSIZE   = 4;
	localparam int LANE_BW = 2;
	localparam int GBW     = 16;
	// Signed tile origin
	localparam int CBW     = 8;
	localparam int DIM_BW  = 8;
	localparam int ROW_BW  = 4;

	//========================================
	// Types
	//========================================
	// One SRAM row with lane 0 in the low word
	typedef logic [VSIZE-1:0][DATA_BW-1:0] data_vec_t;

	// Tile request with two's complement x0 and y0
	typedef struct packed {
		logic [GBW-1:0]     base_addr;
		logic [CBW-1:0]     x0;
		logic [CBW-1:0]     y0;
		logic [DIM_BW-1:0]  width;
		logic [DIM_BW-1:0]  height;
		logic [ROW_BW-1:0]  rows;
		logic [7:0]         sram_row;
		logic [DATA_BW-1:0] pad_value;
		logic [LANE_BW-1:0] xor_mask;
	} dma_req_t;

	// First-row address and lane validity
	typedef struct packed {
		logic [GBW-1:0]   row0_addr;
		logic [VSIZE-1:0] col_mask;
	} head_t;

	// Per-row write command
	typedef struct packed {
		logic             fetch;
		logic [VSIZE-1:0] col_mask;
		logic             last;
	} row_cmd_t;

endpackage
